// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the tlk2711 transmit testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

# the error limit keeps the run going after an assertion fires,
# so the testbench can print its own summary
verilator --binary --assert --timing -j 0 \
        --top-module tlk2711_tx_tb -f tb.f -o tlk2711_tx_sim \
    && ./obj_dir/tlk2711_tx_sim +verilator+error+limit+1000 \
        | tee /dev/stderr \
        | grep -qF '*** PASSED ***' \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }

// ==== source/dma_unpacker.sv ====
`timescale 1ns/1ps
`default_nettype none

module dma_unpacker (
    input  logic                  clk,
    input  logic                  i_soft_reset,
    input  logic                  i_dma_valid,
    input  tlk_tx_pkg::dma_beat_t i_dma_data,
    output logic                  o_dma_ready,
    halfword_fifo_if.writer       wr
);
    import tlk_tx_pkg::*;

    // held beat, viewed as halfwords with index 0 the lowest
    halfword_t [HALFWORDS_PER_BEAT-1:0] beat_q;
    logic [1:0]                         hw_idx;
    logic                               busy;
    logic                               beat_accept;

    //////////////////////////////
    // dma handshake
    //////////////////////////////

    // only take a beat when all four halfwords are sure to fit
    assign o_dma_ready = !busy && wr.room_for_beat;
    assign beat_accept = i_dma_valid && o_dma_ready;

    always_ff @(posedge clk) begin
        if (beat_accept) begin
            beat_q <= i_dma_data;
        end
    end

    //////////////////////////////
    // halfword serializer
    //////////////////////////////

    // busy for exactly four cycles after each accepted beat
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            busy   <= 1'b0;
            hw_idx <= 2'd0;
        end else if (beat_accept) begin
            busy   <= 1'b1;
            hw_idx <= 2'd0;
        end else if (busy) begin
            hw_idx <= hw_idx + 2'd1;
            if (hw_idx == 2'(HALFWORDS_PER_BEAT - 1)) begin
                busy <= 1'b0;
            end
        end
    end

    // one write per busy cycle, lowest halfword first
    assign wr.wr_strobe = busy;
    assign wr.wr_data   = beat_q[hw_idx];

endmodule

`default_nettype wire

// ==== source/frame_transmitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_transmitter #(
    parameter int SYNC_CYCLES = 6,
    parameter int GAP_CYCLES  = 16
) (
    input  logic                  clk,
    input  logic                  i_soft_reset,
    input  logic                  i_tx_start,
    input  tlk_tx_pkg::tx_mode_e  i_tx_mode,
    input  logic [15:0]           i_tx_packet_body,
    input  logic [15:0]           i_tx_packet_tail,
    input  logic [15:0]           i_tx_body_num,
    halfword_fifo_if.reader       rd,
    output logic                  o_tx_interrupt,
    output logic                  o_2711_loopen,
    output logic                  o_2711_tkmsb,
    output logic                  o_2711_tklsb,
    output tlk_tx_pkg::halfword_t o_2711_txd
);
    import tlk_tx_pkg::*;

    localparam int SYNC_W = $clog2(SYNC_CYCLES + 1);
    localparam int GAP_W  = $clog2(GAP_CYCLES + 1);

    tx_state_e         state;
    tx_mode_e          tx_mode;
    logic              start_seen;
    logic [15:0]       body_len;
    logic [15:0]       tail_len;
    logic [15:0]       body_num;
    logic [15:0]       frame_cnt;
    logic [SYNC_W-1:0] sync_cnt;
    logic              head_cnt;
    logic [14:0]       data_cnt;
    logic [GAP_W-1:0]  gap_cnt;
    halfword_t         csum;

    logic              last_frame;
    halfword_t         frame_len;
    logic [14:0]       frame_hw;
    logic              kcode_on;
    logic              pop;
    logic              sync_done;
    logic              gap_done;
    logic              data_done;

    halfword_t         next_txd;
    logic              next_tkmsb;
    logic              next_tklsb;

    //////////////////////////////
    // transfer setup
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (i_tx_start) begin
            body_len <= i_tx_packet_body;
            tail_len <= i_tx_packet_tail;
            body_num <= i_tx_body_num;
        end
    end

    // start is remembered until the frame sequence begins
    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            tx_mode    <= MODE_NORMAL;
            start_seen <= 1'b0;
        end else if (i_tx_start) begin
            tx_mode    <= i_tx_mode;
            start_seen <= 1'b1;
        end else if (state == ST_BEGIN) begin
            start_seen <= 1'b0;
        end
    end

    assign last_frame = (frame_cnt == body_num);
    assign frame_len  = last_frame ? tail_len : body_len;
    assign frame_hw   = frame_len[15:1];

    // k-code words start the cycle after the start strobe
    assign kcode_on = (tx_mode == MODE_KCODE) || (i_tx_start && i_tx_mode == MODE_KCODE);

    // data phase stalls on an empty buffer
    assign pop          = (state == ST_VLD_DATA) && !rd.empty;
    assign rd.rd_strobe = pop;

    assign sync_done = (sync_cnt == SYNC_W'(SYNC_CYCLES - 1));
    assign gap_done  = (gap_cnt == GAP_W'(GAP_CYCLES - 1));
    assign data_done = pop && (data_cnt == frame_hw - 15'd1);

    //////////////////////////////
    // frame fsm
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_seen && tx_mode != MODE_KCODE && !rd.empty) begin
                        state <= ST_BEGIN;
                    end
                end
                ST_BEGIN:     state <= ST_SYNC;
                ST_SYNC:      state <= sync_done ? ST_SOF : ST_SYNC;
                ST_SOF:       state <= ST_HEAD;
                ST_HEAD:      state <= head_cnt ? ST_FILE_SIGN : ST_HEAD;
                ST_FILE_SIGN: state <= ST_FRAME_NUM;
                ST_FRAME_NUM: state <= ST_VLD_DLEN;
                // zero length frame skips the data phase
                ST_VLD_DLEN:  state <= (frame_hw == '0) ? ST_CHECKSUM : ST_VLD_DATA;
                ST_VLD_DATA:  state <= data_done ? ST_CHECKSUM : ST_VLD_DATA;
                ST_CHECKSUM:  state <= ST_EOF;
                ST_EOF:       state <= ST_GAP;
                ST_GAP: begin
                    if (gap_done) begin
                        state <= last_frame ? ST_IDLE : ST_SOF;
                    end
                end
                default:      state <= ST_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // counters and checksum
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            sync_cnt  <= '0;
            head_cnt  <= 1'b0;
            gap_cnt   <= '0;
            data_cnt  <= '0;
            frame_cnt <= '0;
            csum      <= '0;
        end else begin
            sync_cnt <= (state == ST_SYNC) ? sync_cnt + 1'b1 : '0;
            head_cnt <= (state == ST_HEAD) ? ~head_cnt : 1'b0;
            gap_cnt  <= (state == ST_GAP) ? gap_cnt + 1'b1 : '0;

            if (state == ST_SOF) begin
                data_cnt <= '0;
            end else if (pop) begin
                data_cnt <= data_cnt + 15'd1;
            end

            // frame number advances as the gap ends
            if (state == ST_IDLE) begin
                frame_cnt <= '0;
            end else if (state == ST_GAP && gap_done) begin
                frame_cnt <= frame_cnt + 16'd1;
            end

            // sum of frame number, length and data, comma cycles excluded
            case (state)
                ST_SOF:       csum <= '0;
                ST_FRAME_NUM: csum <= csum + frame_cnt;
                ST_VLD_DLEN:  csum <= csum + frame_len;
                ST_VLD_DATA:  csum <= pop ? csum + rd.rd_data : csum;
                default:      csum <= csum;
            endcase
        end
    end

    //////////////////////////////
    // link word
    //////////////////////////////

    always_comb begin
        next_txd   = '0;
        next_tkmsb = 1'b0;
        next_tklsb = 1'b0;
        if (kcode_on) begin
            next_txd   = {K28_2, K27_7};
            next_tkmsb = 1'b1;
            next_tklsb = 1'b1;
        end else begin
            case (state)
                ST_SYNC, ST_GAP: begin
                    next_txd   = {D5_6, K28_5};
                    next_tklsb = 1'b1;
                end
                ST_SOF: begin
                    next_txd   = {K28_2, K27_7};
                    next_tkmsb = 1'b1;
                    next_tklsb = 1'b1;
                end
                ST_HEAD:      next_txd = head_cnt ? HEAD_1 : HEAD_0;
                ST_FILE_SIGN: next_txd = {TX_IND, (last_frame ? FILE_END : 8'h00)};
                ST_FRAME_NUM: next_txd = frame_cnt;
                ST_VLD_DLEN:  next_txd = frame_len;
                ST_VLD_DATA: begin
                    // comma fills a cycle with nothing to send
                    next_txd   = pop ? rd.rd_data : {D5_6, K28_5};
                    next_tklsb = !pop;
                end
                ST_CHECKSUM:  next_txd = csum;
                ST_EOF: begin
                    next_txd   = {K29_7, K30_7};
                    next_tkmsb = 1'b1;
                    next_tklsb = 1'b1;
                end
                default:      next_txd = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            o_2711_txd     <= '0;
            o_2711_tkmsb   <= 1'b0;
            o_2711_tklsb   <= 1'b0;
            o_2711_loopen  <= 1'b0;
            o_tx_interrupt <= 1'b0;
        end else begin
            o_2711_txd     <= next_txd;
            o_2711_tkmsb   <= next_tkmsb;
            o_2711_tklsb   <= next_tklsb;
            o_2711_loopen  <= (tx_mode == MODE_LOOPBACK);
            o_tx_interrupt <= (state == ST_GAP) && gap_done && last_frame;
        end
    end

endmodule

`default_nettype wire

// ==== source/halfword_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module halfword_fifo #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic            clk,
    input  logic            i_soft_reset,
    halfword_fifo_if.buffer port
);
    import tlk_tx_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    // room threshold, a whole beat must still fit
    localparam logic [PTR_W:0] ROOM_LIMIT = (PTR_W + 1)'(FIFO_DEPTH - HALFWORDS_PER_BEAT);

    halfword_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    // wrap explicitly so any depth works
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        logic [PTR_W-1:0] nxt;
        nxt = (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
        return nxt;
    endfunction

    //////////////////////////////
    // storage
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (port.wr_strobe) begin
            mem[wr_ptr] <= port.wr_data;
        end
    end

    // fall-through read of the head entry
    assign port.rd_data = mem[rd_ptr];

    //////////////////////////////
    // pointers and occupancy
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (port.wr_strobe) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (port.rd_strobe) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({port.wr_strobe, port.rd_strobe})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign port.empty         = (count == '0);
    assign port.room_for_beat = (count <= ROOM_LIMIT);

endmodule

`default_nettype wire

// ==== source/halfword_fifo_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface halfword_fifo_if;
    import tlk_tx_pkg::*;

    // write side, one halfword per strobe
    logic      wr_strobe;
    halfword_t wr_data;
    logic      room_for_beat;

    // read side, head entry always presented
    logic      rd_strobe;
    halfword_t rd_data;
    logic      empty;

    modport writer (
        output wr_strobe,
        output wr_data,
        input  room_for_beat
    );

    modport buffer (
        input  wr_strobe,
        input  wr_data,
        output room_for_beat,
        input  rd_strobe,
        output rd_data,
        output empty
    );

    modport reader (
        output rd_strobe,
        input  rd_data,
        input  empty
    );

endinterface

`default_nettype wire

// ==== source/tlk2711_tx_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlk2711_tx_top #(
    parameter int FIFO_DEPTH  = 64,
    parameter int SYNC_CYCLES = 6,
    parameter int GAP_CYCLES  = 16
) (
    input  logic        clk,
    input  logic        i_soft_reset,

    // transfer control
    input  logic        i_tx_start,
    input  logic [3:0]  i_tx_mode,
    input  logic [15:0] i_tx_packet_body,
    input  logic [15:0] i_tx_packet_tail,
    input  logic [15:0] i_tx_body_num,

    // dma source
    input  logic        i_dma_valid,
    input  logic [63:0] i_dma_data,
    output logic        o_dma_ready,

    // tlk2711 link
    output logic        o_tx_interrupt,
    output logic        o_2711_loopen,
    output logic        o_2711_tkmsb,
    output logic        o_2711_tklsb,
    output logic [15:0] o_2711_txd
);
    import tlk_tx_pkg::*;

    halfword_fifo_if hw_if ();

    dma_unpacker u_unpacker (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_dma_valid  (i_dma_valid),
        .i_dma_data   (i_dma_data),
        .o_dma_ready  (o_dma_ready),
        .wr           (hw_if)
    );

    halfword_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .port         (hw_if)
    );

    frame_transmitter #(
        .SYNC_CYCLES (SYNC_CYCLES),
        .GAP_CYCLES  (GAP_CYCLES)
    ) u_tx (
        .clk              (clk),
        .i_soft_reset     (i_soft_reset),
        .i_tx_start       (i_tx_start),
        .i_tx_mode        (tx_mode_e'(i_tx_mode)),
        .i_tx_packet_body (i_tx_packet_body),
        .i_tx_packet_tail (i_tx_packet_tail),
        .i_tx_body_num    (i_tx_body_num),
        .rd               (hw_if),
        .o_tx_interrupt   (o_tx_interrupt),
        .o_2711_loopen    (o_2711_loopen),
        .o_2711_tkmsb     (o_2711_tkmsb),
        .o_2711_tklsb     (o_2711_tklsb),
        .o_2711_txd       (o_2711_txd)
    );

endmodule

`default_nettype wire

// ==== source/tlk_tx_pkg.sv ====
`default_nettype none

package tlk_tx_pkg;

    //////////////////////////////
    // data types
    //////////////////////////////

    // one word on the tlk2711 parallel port
    typedef logic [15:0] halfword_t;

    // halfwords carried by one dma beat
    localparam int HALFWORDS_PER_BEAT = 4;

    // one beat from the dma source
    typedef logic [HALFWORDS_PER_BEAT*16-1:0] dma_beat_t;

    //////////////////////////////
    // link codes
    //////////////////////////////

    // comma, sent as {D5_6, K28_5} with tklsb only
    localparam logic [7:0] K28_5 = 8'hBC;
    localparam logic [7:0] D5_6  = 8'hC5;

    // start of frame, {K28_2, K27_7} with both flags
    localparam logic [7:0] K27_7 = 8'hFB;
    localparam logic [7:0] K28_2 = 8'h5C;

    // end of frame, {K29_7, K30_7} with both flags
    localparam logic [7:0] K30_7 = 8'hFE;
    localparam logic [7:0] K29_7 = 8'hFD;

    // frame header words
    localparam logic [15:0] HEAD_0 = 16'hEB90;
    localparam logic [15:0] HEAD_1 = 16'hE116;

    // file sign, low byte marks the last frame of a transfer
    localparam logic [7:0] TX_IND   = 8'h81;
    localparam logic [7:0] FILE_END = 8'h01;

    //////////////////////////////
    // modes and states
    //////////////////////////////

    typedef enum logic [3:0] {
        MODE_NORMAL   = 4'd0,
        MODE_LOOPBACK = 4'd1,
        MODE_KCODE    = 4'd2
    } tx_mode_e;

    typedef enum logic [3:0] {
        ST_IDLE      = 4'd0,
        ST_BEGIN     = 4'd1,
        ST_SYNC      = 4'd2,
        ST_SOF       = 4'd3,
        ST_HEAD      = 4'd4,
        ST_FILE_SIGN = 4'd5,
        ST_FRAME_NUM = 4'd6,
        ST_VLD_DLEN  = 4'd7,
        ST_VLD_DATA  = 4'd8,
        ST_CHECKSUM  = 4'd9,
        ST_EOF       = 4'd10,
        ST_GAP       = 4'd11
    } tx_state_e;

endpackage

`default_nettype wire

// ==== tb.f ====
source/tlk_tx_pkg.sv
source/halfword_fifo_if.sv
source/dma_unpacker.sv
source/halfword_fifo.sv
source/frame_transmitter.sv
source/tlk2711_tx_top.sv
verif/frame_transmitter_props.sv
verif/tlk2711_tx_tb.sv

// ==== verif/frame_transmitter_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_transmitter_props (
    input logic clk,
    input logic i_soft_reset,
    input logic o_tx_interrupt,
    input logic o_2711_tkmsb,
    input logic o_2711_tklsb,
    input logic rd_strobe,
    input logic rd_empty
);
    // read back by the testbench summary
    int fail_count = 0;

    // interrupt is a single-cycle pulse
    assert property (@(posedge clk) disable iff (i_soft_reset)
        o_tx_interrupt |=> !o_tx_interrupt)
    else begin
        $error("interrupt high for more than one cycle");
        fail_count++;
    end

    // no K code in the high byte without one in the low byte
    assert property (@(posedge clk) disable iff (i_soft_reset)
        o_2711_tkmsb |-> o_2711_tklsb)
    else begin
        $error("tkmsb set while tklsb clear");
        fail_count++;
    end

    assert property (@(posedge clk) disable iff (i_soft_reset)
        rd_strobe |-> !rd_empty)
    else begin
        $error("buffer read while empty");
        fail_count++;
    end

endmodule

bind frame_transmitter frame_transmitter_props u_props (
    .clk            (clk),
    .i_soft_reset   (i_soft_reset),
    .o_tx_interrupt (o_tx_interrupt),
    .o_2711_tkmsb   (o_2711_tkmsb),
    .o_2711_tklsb   (o_2711_tklsb),
    .rd_strobe      (rd.rd_strobe),
    .rd_empty       (rd.empty)
);

`default_nettype wire

// ==== verif/tlk2711_tx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlk2711_tx_tb;
    import tlk_tx_pkg::*;

    localparam int SYNC_CYCLES = 6;
    localparam int GAP_CYCLES  = 16;
    localparam int MAX_FRAMES  = 4;
    localparam int MAX_HW      = 20;

    // longest frame from begin cycle to end of gap
    localparam int FRAME_CYCLES    = 1 + SYNC_CYCLES + 6 + MAX_HW + 2 + GAP_CYCLES;
    localparam int TRANSFERS       = 5;
    localparam int WATCHDOG_CYCLES = 2 * TRANSFERS * MAX_FRAMES * FRAME_CYCLES + 1000;

    // link samples as {14'b0, tkmsb, tklsb, txd}
    localparam logic [31:0] IDLE_W  = 32'h0;
    localparam logic [31:0] COMMA_W = {16'h0001, D5_6, K28_5};
    localparam logic [31:0] SOF_W   = {16'h0003, K28_2, K27_7};
    localparam logic [31:0] EOF_W   = {16'h0003, K29_7, K30_7};
    localparam logic [31:0] HEAD0_W = {16'h0000, HEAD_0};
    localparam logic [31:0] HEAD1_W = {16'h0000, HEAD_1};

    logic        clk;
    logic        i_soft_reset;
    logic        i_tx_start;
    logic [3:0]  i_tx_mode;
    logic [15:0] i_tx_packet_body;
    logic [15:0] i_tx_packet_tail;
    logic [15:0] i_tx_body_num;
    logic        i_dma_valid;
    logic [63:0] i_dma_data;
    logic        o_dma_ready;
    logic        o_tx_interrupt;
    logic        o_2711_loopen;
    logic        o_2711_tkmsb;
    logic        o_2711_tklsb;
    logic [15:0] o_2711_txd;

    integer      seed = 32'h42ed;
    int          checks;
    int          errors;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    int          irq_count;
    logic        abort_feed;

    // current transfer and its model data
    tx_mode_e    cur_mode;
    logic [15:0] cur_body;
    logic [15:0] cur_tail;
    logic [15:0] cur_num;
    dma_beat_t   beats[$];
    halfword_t   exp_hw[$];

    tlk2711_tx_top DUT (
        .clk              (clk),
        .i_soft_reset     (i_soft_reset),
        .i_tx_start       (i_tx_start),
        .i_tx_mode        (i_tx_mode),
        .i_tx_packet_body (i_tx_packet_body),
        .i_tx_packet_tail (i_tx_packet_tail),
        .i_tx_body_num    (i_tx_body_num),
        .i_dma_valid      (i_dma_valid),
        .i_dma_data       (i_dma_data),
        .o_dma_ready      (o_dma_ready),
        .o_tx_interrupt   (o_tx_interrupt),
        .o_2711_loopen    (o_2711_loopen),
        .o_2711_tkmsb     (o_2711_tkmsb),
        .o_2711_tklsb     (o_2711_tklsb),
        .o_2711_txd       (o_2711_txd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act == exp) else begin
            $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
        errors      = errors + test_errors;
        test_errors = 0;
    endtask

    task automatic apply_reset(input int cycles);
        @(negedge clk);
        i_soft_reset = 1'b1;
        i_tx_start   = 1'b0;
        i_dma_valid  = 1'b0;
        repeat (cycles) @(negedge clk);
        i_soft_reset = 1'b0;
    endtask

    // outputs are registered, so the falling edge sees them settled
    task automatic sample_link(output logic [31:0] word);
        @(negedge clk);
        word = {14'd0, o_2711_tkmsb, o_2711_tklsb, o_2711_txd};
        if (o_tx_interrupt) begin
            irq_count++;
        end
    endtask

    // leaves the first word after the run in w
    task automatic count_commas(inout logic [31:0] w, output int run);
        run = 0;
        while (w == COMMA_W) begin
            run++;
            sample_link(w);
        end
    endtask

    task automatic build_transfer(input logic [15:0] n_body, input tx_mode_e mode);
        int        total;
        dma_beat_t beat;
        cur_mode = mode;
        cur_num  = n_body;
        cur_body = 16'(2 * (1 + {$random(seed)} % 20));
        cur_tail = 16'(2 * (1 + {$random(seed)} % 20));
        total    = int'(cur_num) * int'(cur_body) / 2 + int'(cur_tail) / 2;
        beats.delete();
        exp_hw.delete();
        for (int b = 0; b < (total + 3) / 4; b++) begin
            beat = {$random(seed), $random(seed)};
            beats.push_back(beat);
            // lowest halfword goes out first
            for (int h = 0; h < HALFWORDS_PER_BEAT; h++) begin
                exp_hw.push_back(beat[16*h +: 16]);
            end
        end
    endtask

    task automatic start_transfer();
        @(negedge clk);
        i_tx_start       = 1'b1;
        i_tx_mode        = cur_mode;
        i_tx_packet_body = cur_body;
        i_tx_packet_tail = cur_tail;
        i_tx_body_num    = cur_num;
        @(negedge clk);
        i_tx_start = 1'b0;
    endtask

    // gap_pct is the chance in percent of a cycle without dma valid
    task automatic feed_dma(input int gap_pct);
        int idx;
        idx = 0;
        while (idx < beats.size() && !abort_feed) begin
            @(negedge clk);
            i_dma_valid = ({$random(seed)} % 100) >= gap_pct;
            i_dma_data  = beats[idx];
            if (i_dma_valid && o_dma_ready) begin
                idx++;
            end
        end
        @(negedge clk);
        i_dma_valid = 1'b0;
    endtask

    //////////////////////////////
    // frame model and parser
    //////////////////////////////

    task automatic parse_transfer(input string name);
        logic [31:0] w;
        int          run;
        int          hw_idx;
        logic [15:0] len;
        logic [15:0] sum;
        logic        last;
        hw_idx    = 0;
        irq_count = 0;
        w         = IDLE_W;
        while (w == IDLE_W) begin
            sample_link(w);
        end
        count_commas(w, run);
        check_value({name, " sync"}, SYNC_CYCLES, run);
        for (int f = 0; f <= int'(cur_num); f++) begin
            last = (f == int'(cur_num));
            len  = last ? cur_tail : cur_body;
            check_value({name, " sof"}, SOF_W, w);
            check_value({name, " loopen"}, {31'd0, cur_mode == MODE_LOOPBACK},
                        {31'd0, o_2711_loopen});
            sample_link(w);
            check_value({name, " head0"}, HEAD0_W, w);
            sample_link(w);
            check_value({name, " head1"}, HEAD1_W, w);
            sample_link(w);
            check_value({name, " file sign"}, {16'd0, TX_IND, (last ? FILE_END : 8'h00)}, w);
            sample_link(w);
            check_value({name, " frame number"}, {16'd0, 16'(f)}, w);
            sample_link(w);
            check_value({name, " length"}, {16'd0, len}, w);
            sum = 16'(f) + len;
            for (int i = 0; i < int'(len) / 2; i++) begin
                sample_link(w);
                // commas fill cycles where the buffer ran dry
                while (w == COMMA_W) begin
                    sample_link(w);
                end
                check_value({name, " data"}, {16'd0, exp_hw[hw_idx]}, w);
                sum = sum + exp_hw[hw_idx];
                hw_idx++;
            end
            sample_link(w);
            check_value({name, " checksum"}, {16'd0, sum}, w);
            sample_link(w);
            check_value({name, " eof"}, EOF_W, w);
            check_value({name, " early interrupt"}, 32'd0, irq_count);
            sample_link(w);
            count_commas(w, run);
            check_value({name, " gap"}, GAP_CYCLES, run);
        end
        check_value({name, " idle"}, IDLE_W, w);
        sample_link(w);
        check_value({name, " interrupts"}, 32'd1, irq_count);
    endtask

    task automatic run_transfer(input string name, input int gap_pct);
        start_transfer();
        fork
            feed_dma(gap_pct);
            parse_transfer(name);
        join
    endtask

    task automatic kcode_burst();
        logic [31:0] w;
        irq_count = 0;
        cur_mode  = MODE_KCODE;
        start_transfer();
        repeat (50) begin
            sample_link(w);
            check_value("kcode word", SOF_W, w);
        end
        check_value("kcode interrupt", 32'd0, irq_count);
    endtask

    task automatic reset_mid_frame();
        logic [31:0] w;
        logic        hit;
        build_transfer(16'(1 + {$random(seed)} % 3), MODE_NORMAL);
        start_transfer();
        fork
            feed_dma(30);
            begin
                w = IDLE_W;
                while (w != HEAD1_W) begin
                    sample_link(w);
                end
                // file sign, frame number, length, then the data phase
                repeat (3) begin
                    sample_link(w);
                end
                i_soft_reset = 1'b1;
                abort_feed   = 1'b1;
                hit          = 1'b0;
                repeat (2) begin
                    sample_link(w);
                    if (w == IDLE_W) begin
                        hit = 1'b1;
                    end
                end
                checks++;
                assert (hit) else begin
                    $display("soft_reset: no idle word within 2 cycles of a soft reset");
                    test_errors++;
                end
                i_soft_reset = 1'b0;
            end
        join
        abort_feed = 1'b0;
        build_transfer(16'(1 + {$random(seed)} % 3), MODE_NORMAL);
        run_transfer("after_reset", 30);
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        i_soft_reset     = 1'b1;
        i_tx_start       = 1'b0;
        i_tx_mode        = 4'd0;
        i_tx_packet_body = 16'd0;
        i_tx_packet_tail = 16'd0;
        i_tx_body_num    = 16'd0;
        i_dma_valid      = 1'b0;
        i_dma_data       = 64'd0;
        abort_feed       = 1'b0;
        checks           = 0;
        errors           = 0;
        test_errors      = 0;
        tests_run        = 0;
        tests_failed     = 0;
        irq_count        = 0;
        repeat (16) @(negedge clk);
        i_soft_reset = 1'b0;

        // ready, interrupt, loopback, flags and word after reset
        @(negedge clk);
        check_value("reset_state", 32'h0010_0000,
                    {11'd0, o_dma_ready, o_tx_interrupt, o_2711_loopen,
                     o_2711_tkmsb, o_2711_tklsb, o_2711_txd});
        finish_test("reset_state");

        apply_reset(2);
        build_transfer(16'd0, MODE_NORMAL);
        run_transfer("single_frame", 0);
        finish_test("single_frame");

        apply_reset(2);
        build_transfer(16'(1 + {$random(seed)} % 3), MODE_NORMAL);
        run_transfer("multi_frame", 30);
        finish_test("multi_frame");

        // same parameters and beats as the previous test
        apply_reset(2);
        cur_mode = MODE_LOOPBACK;
        run_transfer("loopback", 30);
        finish_test("loopback");

        apply_reset(2);
        kcode_burst();
        finish_test("kcode");

        apply_reset(2);
        reset_mid_frame();
        finish_test("soft_reset");

        errors = errors + DUT.u_tx.u_props.fail_count;
        $display("tests %0d, failed %0d, checks %0d, property failures %0d, errors %0d",
                 tests_run, tests_failed, checks, DUT.u_tx.u_props.fail_count, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
